//--- files.f
design/rvIsaPkg.sv
design/rvCtrlPkg.sv
design/instDecoder.sv
design/regFile.sv
design/aluExecute.sv
design/memResult.sv
design/pcUnit.sv
design/rvCore.sv
testbench/rvCore_assertions.sv
testbench/rvCoreTb.sv

//--- run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
	-f files.f --top-module rvCoreTb -o rvCoreSim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/rvCoreSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -qx "All checks passed" "$logFile"; then
	exit 0
fi
echo "pass message not found in $logFile"
exit 1

//--- testbench/rvCoreTb.sv
`default_nettype none

module rvCoreTb;

	timeunit 1ns;
	timeprecision 1ns;

	localparam int dmemWords = 256;
	localparam int idxW = $clog2(dmemWords);

	logic             clk = 1'b0;
	logic             rstN;
	rvIsaPkg::word    inst;
	logic             instValid;
	rvIsaPkg::word    pc;
	logic             halted;
	logic             retireValid;
	rvIsaPkg::regAddr retireRd;
	rvIsaPkg::word    retireData;
	rvIsaPkg::word    retirePc;

	int            errCount = 0;
	rvIsaPkg::word regModel [32];
	rvIsaPkg::word memModel [dmemWords];
	rvIsaPkg::word pcModel;

	rvCore #(.dmemWords(dmemWords)) rvCore_i (
		.clk(clk), .rstN(rstN), .inst(inst), .instValid(instValid), .pc(pc),
		.halted(halted), .retireValid(retireValid), .retireRd(retireRd),
		.retireData(retireData), .retirePc(retirePc)
	);

	always #50 clk = ~clk;

	task automatic checkWord(input string name, input rvIsaPkg::word got,
			input rvIsaPkg::word exp);
		if (got !== exp) begin
			errCount++;
			$display("mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic checkRegAddr(input string name, input rvIsaPkg::regAddr got,
			input rvIsaPkg::regAddr exp);
		if (got !== exp) begin
			errCount++;
			$display("mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errCount++;
			$display("mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// instruction encodings
	function automatic rvIsaPkg::word rType(input logic [6:0] f7, input rvIsaPkg::regAddr rs2,
			input rvIsaPkg::regAddr rs1, input logic [2:0] f3, input rvIsaPkg::regAddr rd);
		return {f7, rs2, rs1, f3, rd, rvIsaPkg::opReg};
	endfunction

	function automatic rvIsaPkg::word iType(input logic [11:0] imm, input rvIsaPkg::regAddr rs1,
			input logic [2:0] f3, input rvIsaPkg::regAddr rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic rvIsaPkg::word sType(input logic [11:0] imm, input rvIsaPkg::regAddr rs2,
			input rvIsaPkg::regAddr rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], rvIsaPkg::opStore};
	endfunction

	function automatic rvIsaPkg::word bType(input logic [12:0] off, input rvIsaPkg::regAddr rs2,
			input rvIsaPkg::regAddr rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rvIsaPkg::opBranch};
	endfunction

	function automatic rvIsaPkg::word uType(input logic [19:0] imm, input rvIsaPkg::regAddr rd,
			input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic rvIsaPkg::word jType(input logic [20:0] off, input rvIsaPkg::regAddr rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, rvIsaPkg::opJal};
	endfunction

	// reference model
	function automatic rvIsaPkg::word refAlu(input logic [2:0] f3, input logic alt,
			input rvIsaPkg::word a, input rvIsaPkg::word b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: return alt ? rvIsaPkg::word'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic refBranch(input logic [2:0] f3, input rvIsaPkg::word a,
			input rvIsaPkg::word b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	function automatic rvIsaPkg::word refLoad(input logic [2:0] f3, input rvIsaPkg::word addr);
		rvIsaPkg::word w;
		rvIsaPkg::word b;
		rvIsaPkg::word h;
		w = memModel[addr[idxW+1:2]];
		b = w >> {addr[1:0], 3'b000};
		h = w >> {addr[1], 4'b0000};
		case (f3)
			3'd0: return {{24{b[7]}}, b[7:0]};
			3'd4: return {24'h0, b[7:0]};
			3'd1: return {{16{h[15]}}, h[15:0]};
			3'd5: return {16'h0, h[15:0]};
			default: return w;
		endcase
	endfunction

	task automatic storeModel(input logic [2:0] f3, input rvIsaPkg::word addr,
			input rvIsaPkg::word data);
		rvIsaPkg::word w;
		w = memModel[addr[idxW+1:2]];
		case (f3)
			3'd0: w[{addr[1:0], 3'b000} +: 8] = data[7:0];
			3'd1: w[{addr[1], 4'b0000} +: 16] = data[15:0];
			default: w = data;
		endcase
		memModel[addr[idxW+1:2]] = w;
	endtask

	task automatic issueInst(input rvIsaPkg::word instr);
		@(negedge clk);
		inst = instr;
		instValid = 1'b1;
		@(negedge clk);
		instValid = 1'b0;
	endtask

	task automatic waitRetire(output logic seen);
		int n;
		n = 0;
		while (!retireValid && n < 20) begin
			@(negedge clk);
			n++;
		end
		seen = retireValid;
		if (!seen) begin
			errCount++;
			$display("no retire arrived within 20 cycles of the strobe");
		end
	endtask

	// expRd of zero means no register write
	task automatic runInstTo(input rvIsaPkg::word instr, input rvIsaPkg::regAddr expRd,
			input rvIsaPkg::word expData, input rvIsaPkg::word expNext);
		logic seen;
		rvIsaPkg::word startPc;
		startPc = pcModel;
		issueInst(instr);
		waitRetire(seen);
		if (seen) begin
			checkWord("retirePc", retirePc, startPc);
			checkRegAddr("retireRd", retireRd, expRd);
			checkWord("retireData", retireData, expData);
			checkWord("pc", pc, expNext);
		end
		if (expRd != '0) begin
			regModel[expRd] = expData;
		end
		pcModel = expNext;
	endtask

	task automatic runInst(input rvIsaPkg::word instr, input rvIsaPkg::regAddr expRd,
			input rvIsaPkg::word expData);
		runInstTo(instr, expRd, expData, pcModel + 32'd4);
	endtask

	// lui then addi with the upper part rounded for the sign of the low 12 bits
	task automatic loadReg(input rvIsaPkg::regAddr rd, input rvIsaPkg::word value);
		rvIsaPkg::word upper;
		upper = value + 32'h800;
		runInst(uType(upper[31:12], rd, rvIsaPkg::opLui), rd, {upper[31:12], 12'h000});
		runInst(iType(value[11:0], rd, 3'd0, rd, rvIsaPkg::opImm), rd, value);
	endtask

	task automatic aluOps();
		rvIsaPkg::word a;
		rvIsaPkg::word b;
		rvIsaPkg::word rnd;
		logic [11:0] imm;
		logic [2:0] f3;
		logic alt;
		for (int k = 0; k < 6; k++) begin
			a = $urandom;
			b = $urandom;
			loadReg(5'd1, a);
			loadReg(5'd2, b);
			// eight funct3 codes plus sub and sra
			for (int op = 0; op < 10; op++) begin
				f3 = (op < 8) ? 3'(op) : ((op == 8) ? 3'd0 : 3'd5);
				alt = (op >= 8);
				runInst(rType(alt ? rvIsaPkg::f7Alt : rvIsaPkg::f7Base, 5'd2, 5'd1, f3, 5'd3),
					5'd3, refAlu(f3, alt, a, b));
			end
			for (int op = 0; op < 9; op++) begin
				f3 = (op < 8) ? 3'(op) : 3'd5;
				alt = (op == 8);
				rnd = $urandom;
				if (f3 == 3'd1 || f3 == 3'd5) begin
					imm = {alt ? 7'b0100000 : 7'b0000000, rnd[4:0]};
				end else begin
					imm = rnd[11:0];
				end
				runInst(iType(imm, 5'd1, f3, 5'd4, rvIsaPkg::opImm), 5'd4,
					refAlu(f3, alt, a, {{20{imm[11]}}, imm}));
			end
		end
	endtask

	task automatic zeroRegister();
		runInst(iType(12'h055, 5'd1, 3'd0, 5'd0, rvIsaPkg::opImm), 5'd0, 32'd0);
		runInst(rType(rvIsaPkg::f7Base, 5'd1, 5'd2, 3'd0, 5'd0), 5'd0, 32'd0);
		// x0 as a source after the writes above
		runInst(iType(12'h123, 5'd0, 3'd6, 5'd5, rvIsaPkg::opImm), 5'd5, 32'h123);
		runInst(rType(rvIsaPkg::f7Base, 5'd0, 5'd0, 3'd0, 5'd6), 5'd6, 32'd0);
	endtask

	task automatic memoryAccess();
		rvIsaPkg::word rnd;
		rvIsaPkg::word base;
		logic [1:0] bOff;
		logic [1:0] hOff;
		logic [2:0] loadKinds [5];
		loadKinds = '{3'd0, 3'd4, 3'd1, 3'd5, 3'd2};
		for (int k = 0; k < 8; k++) begin
			rnd = $urandom;
			loadReg(5'd1, rnd);
			rnd = $urandom;
			loadReg(5'd2, rnd);
			rnd = $urandom;
			loadReg(5'd3, rnd);
			rnd = $urandom;
			base = (rnd % dmemWords) * 4;
			bOff = rnd[17:16];
			hOff = rnd[19:18];
			loadReg(5'd4, base);
			runInst(sType(12'd0, 5'd1, 5'd4, 3'd2), 5'd0, 32'd0);
			storeModel(3'd2, base, regModel[1]);
			runInst(sType({10'd0, bOff}, 5'd2, 5'd4, 3'd0), 5'd0, 32'd0);
			storeModel(3'd0, base + bOff, regModel[2]);
			// odd half offsets land on the cleared address
			runInst(sType({10'd0, hOff}, 5'd3, 5'd4, 3'd1), 5'd0, 32'd0);
			storeModel(3'd1, base + hOff, regModel[3]);
			for (int o = 0; o < 4; o++) begin
				for (int j = 0; j < 5; j++) begin
					runInst(iType(12'(o), 5'd4, loadKinds[j], 5'd5, rvIsaPkg::opLoad), 5'd5,
						refLoad(loadKinds[j], base + o));
				end
			end
		end
	endtask

	task automatic controlFlow();
		rvIsaPkg::word a;
		rvIsaPkg::word b;
		rvIsaPkg::word rnd;
		rvIsaPkg::word next;
		logic [12:0] bOff;
		logic [20:0] jOff;
		logic [2:0] f3;
		rnd = $urandom;
		runInst(uType(rnd[19:0], 5'd7, rvIsaPkg::opAuipc), 5'd7, pcModel + {rnd[19:0], 12'h000});
		for (int k = 0; k < 8; k++) begin
			a = $urandom;
			rnd = $urandom;
			// equal pairs cover beq taken and bne not taken
			b = (k % 3 == 0) ? a : rnd;
			loadReg(5'd1, a);
			loadReg(5'd2, b);
			for (int f = 0; f < 8; f++) begin
				f3 = 3'(f);
				if (f3 != 3'd2 && f3 != 3'd3) begin
					rnd = $urandom;
					bOff = {{3{rnd[7]}}, rnd[7:0], 2'b00};
					next = refBranch(f3, a, b) ? pcModel + {{19{bOff[12]}}, bOff} : pcModel + 4;
					runInstTo(bType(bOff, 5'd2, 5'd1, f3), 5'd0, 32'd0, next);
				end
			end
			rnd = $urandom;
			jOff = {{11{rnd[7]}}, rnd[7:0], 2'b00};
			runInstTo(jType(jOff, 5'd8), 5'd8, pcModel + 4, pcModel + {{11{jOff[20]}}, jOff});
			rnd = $urandom;
			loadReg(5'd9, {16'h0, rnd[15:0]});
			next = (regModel[9] + {{20{rnd[27]}}, rnd[27:16]}) & ~32'd1;
			runInstTo(iType(rnd[27:16], 5'd9, 3'd0, 5'd10, rvIsaPkg::opJalr), 5'd10,
				pcModel + 4, next);
		end
	endtask

	task automatic strobeTiming();
		@(negedge clk);
		for (int k = 0; k < 4; k++) begin
			@(negedge clk);
			checkBit("retireValid", retireValid, 1'b0);
			checkWord("pc", pc, pcModel);
		end
		// second addi depends on the first
		@(negedge clk);
		inst = iType(12'h001, 5'd11, 3'd0, 5'd11, rvIsaPkg::opImm);
		instValid = 1'b1;
		@(negedge clk);
		inst = iType(12'h002, 5'd11, 3'd0, 5'd11, rvIsaPkg::opImm);
		checkBit("retireValid", retireValid, 1'b1);
		checkWord("retireData", retireData, regModel[11] + 1);
		checkWord("retirePc", retirePc, pcModel);
		@(negedge clk);
		instValid = 1'b0;
		checkBit("retireValid", retireValid, 1'b1);
		checkWord("retireData", retireData, regModel[11] + 3);
		checkWord("retirePc", retirePc, pcModel + 4);
		regModel[11] = regModel[11] + 3;
		pcModel = pcModel + 8;
		@(negedge clk);
		checkBit("retireValid", retireValid, 1'b0);
		checkWord("pc", pc, pcModel);
	endtask

	task automatic haltBehavior();
		runInst(rvIsaPkg::ebreakInst, 5'd0, 32'd0);
		checkBit("halted", halted, 1'b1);
		@(negedge clk);
		inst = iType(12'h07f, 5'd0, 3'd0, 5'd12, rvIsaPkg::opImm);
		instValid = 1'b1;
		for (int k = 0; k < 4; k++) begin
			@(negedge clk);
			checkBit("retireValid", retireValid, 1'b0);
			checkWord("pc", pc, pcModel);
			checkBit("halted", halted, 1'b1);
		end
		instValid = 1'b0;
	endtask

	initial begin
		rvIsaPkg::word seedVal;
		seedVal = $urandom(92687);
		rstN = 1'b0;
		inst = '0;
		instValid = 1'b0;
		pcModel = '0;
		for (int i = 0; i < 32; i++) begin
			regModel[i] = '0;
		end
		repeat (10) @(negedge clk);
		rstN = 1'b1;
		aluOps();
		zeroRegister();
		memoryAccess();
		controlFlow();
		strobeTiming();
		haltBehavior();
		$display("run complete, %0d errors", errCount);
		if (errCount == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/rvCore_assertions.sv
`default_nettype none

module rvCore_assertions (
	input wire                   clk,
	input wire                   rstN,
	input wire                   instValid,
	input wire                   halted,
	input wire                   retireValid,
	input wire rvIsaPkg::regAddr retireRd,
	input wire rvIsaPkg::word    pc
);

	timeunit 1ns;
	timeprecision 1ns;

	// a retire needs a strobe in the cycle before
	noRetireWithoutStrobe: assert property (@(posedge clk) disable iff (!rstN)
		!instValid |=> !retireValid)
		else $error("retireValid high in the cycle after instValid was low");

	pcFrozenWhenHalted: assert property (@(posedge clk) disable iff (!rstN)
		halted |=> $stable(pc))
		else $error("pc moved while the core was halted");

	// rd is only reported in a retire cycle
	rdZeroOutsideRetire: assert property (@(posedge clk) disable iff (!rstN)
		!retireValid |-> retireRd == '0)
		else $error("retireRd nonzero while retireValid is low");

endmodule

bind rvCore rvCore_assertions rvCoreChecks_i (
	.clk(clk), .rstN(rstN), .instValid(instValid), .halted(halted),
	.retireValid(retireValid), .retireRd(retireRd), .pc(pc)
);

`default_nettype wire

//--- design/rvCore.sv
`default_nettype none

module rvCore #(
	parameter int dmemWords = 256
) (
	input  wire                clk,
	input  wire                rstN,
	input  wire rvIsaPkg::word inst,
	input  wire                instValid,
	output rvIsaPkg::word      pc,
	output logic               halted,
	output logic               retireValid,
	output rvIsaPkg::regAddr   retireRd,
	output rvIsaPkg::word      retireData,
	output rvIsaPkg::word      retirePc
);

	rvIsaPkg::regAddr  rs1;
	rvIsaPkg::regAddr  rs2;
	rvIsaPkg::regAddr  rd;
	rvIsaPkg::word     imm;
	rvCtrlPkg::aluOp   aluCtrl;
	logic              aluSrcImm;
	logic              aluSrcPc;
	logic              regWrite;
	logic              memWrite;
	logic              memLoad;
	rvCtrlPkg::memSize memSz;
	logic              memUnsigned;
	logic              isBranch;
	rvIsaPkg::funct3   branchFunct;
	logic              isJal;
	logic              isJalr;
	logic              isEbreak;
	rvCtrlPkg::wbSrc   wbSel;
	rvIsaPkg::word     rdata1;
	rvIsaPkg::word     rdata2;
	rvIsaPkg::word     aluResult;
	logic              redirect;
	rvIsaPkg::word     target;
	rvIsaPkg::word     pcPlus4;
	rvIsaPkg::word     wbData;
	logic              commit;

	assign commit = instValid && !halted;

	instDecoder instDecoder_i (
		.inst(inst), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
		.aluCtrl(aluCtrl), .aluSrcImm(aluSrcImm), .aluSrcPc(aluSrcPc),
		.regWrite(regWrite), .memWrite(memWrite), .memLoad(memLoad),
		.memSz(memSz), .memUnsigned(memUnsigned), .isBranch(isBranch),
		.branchFunct(branchFunct), .isJal(isJal), .isJalr(isJalr),
		.isEbreak(isEbreak), .wbSel(wbSel)
	);

	regFile regFile_i (
		.clk(clk), .rstN(rstN), .we(commit && regWrite), .waddr(rd), .wdata(wbData),
		.raddr1(rs1), .raddr2(rs2), .rdata1(rdata1), .rdata2(rdata2)
	);

	aluExecute aluExecute_i (
		.pc(pc), .rdata1(rdata1), .rdata2(rdata2), .imm(imm), .aluCtrl(aluCtrl),
		.aluSrcImm(aluSrcImm), .aluSrcPc(aluSrcPc), .isBranch(isBranch),
		.branchFunct(branchFunct), .isJal(isJal), .isJalr(isJalr),
		.aluResult(aluResult), .redirect(redirect), .target(target)
	);

	memResult #(.dmemWords(dmemWords)) memResult_i (
		.clk(clk), .addr(aluResult), .storeData(rdata2), .memWrite(memWrite),
		.memLoad(memLoad), .memSz(memSz), .memUnsigned(memUnsigned), .wbSel(wbSel),
		.aluResult(aluResult), .pcPlus4(pcPlus4), .commit(commit), .wbData(wbData)
	);

	pcUnit pcUnit_i (
		.clk(clk), .rstN(rstN), .commit(commit), .redirect(redirect), .target(target),
		.isEbreak(isEbreak), .pc(pc), .pcPlus4(pcPlus4), .halted(halted)
	);

	// rd reads zero outside a retire cycle
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			retireValid <= 1'b0;
			retireRd <= '0;
		end else begin
			retireValid <= commit;
			retireRd <= commit ? rd : '0;
		end
	end

	// a write to x0 reports as no write
	always_ff @(posedge clk) begin
		if (commit) begin
			retireData <= (rd != '0) ? wbData : '0;
			retirePc <= pc;
		end
	end

endmodule

`default_nettype wire

//--- design/pcUnit.sv
`default_nettype none

module pcUnit (
	input  wire                clk,
	input  wire                rstN,
	input  wire                commit,
	input  wire                redirect,
	input  wire rvIsaPkg::word target,
	input  wire                isEbreak,
	output rvIsaPkg::word      pc,
	output rvIsaPkg::word      pcPlus4,
	output logic               halted
);

	assign pcPlus4 = pc + 32'd4;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
			halted <= 1'b0;
		end else if (commit) begin
			pc <= redirect ? target : pcPlus4;
			// sticky until reset
			if (isEbreak) begin
				halted <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- design/memResult.sv
`default_nettype none

module memResult #(
	parameter int dmemWords = 256
) (
	input  wire                    clk,
	input  wire rvIsaPkg::word     addr,
	input  wire rvIsaPkg::word     storeData,
	input  wire                    memWrite,
	input  wire                    memLoad,
	input  wire rvCtrlPkg::memSize memSz,
	input  wire                    memUnsigned,
	input  wire rvCtrlPkg::wbSrc   wbSel,
	input  wire rvIsaPkg::word     aluResult,
	input  wire rvIsaPkg::word     pcPlus4,
	input  wire                    commit,
	output rvIsaPkg::word          wbData
);

	localparam int idxW = $clog2(dmemWords);

	rvIsaPkg::word   mem [dmemWords];
	logic [idxW-1:0] wordIdx;
	logic [1:0]      laneOff;
	logic [3:0]      laneEn;
	rvIsaPkg::word   laneData;
	rvIsaPkg::word   readWord;
	rvIsaPkg::word   shifted;
	rvIsaPkg::word   loadVal;

	assign wordIdx = addr[idxW+1:2];

	// low address bits cleared to the access size
	always_comb begin
		case (memSz)
			rvCtrlPkg::memByte: begin
				laneOff = addr[1:0];
				laneEn = 4'b0001 << laneOff;
				laneData = {4{storeData[7:0]}};
			end
			rvCtrlPkg::memHalf: begin
				laneOff = {addr[1], 1'b0};
				laneEn = 4'b0011 << laneOff;
				laneData = {2{storeData[15:0]}};
			end
			default: begin
				laneOff = 2'b00;
				laneEn = 4'b1111;
				laneData = storeData;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (commit && memWrite) begin
			for (int i = 0; i < 4; i++) begin
				if (laneEn[i]) begin
					mem[wordIdx][i*8 +: 8] <= laneData[i*8 +: 8];
				end
			end
		end
	end

	assign readWord = mem[wordIdx];
	assign shifted = readWord >> {laneOff, 3'b000};

	always_comb begin
		case (memSz)
			rvCtrlPkg::memByte: loadVal = {{24{~memUnsigned & shifted[7]}}, shifted[7:0]};
			rvCtrlPkg::memHalf: loadVal = {{16{~memUnsigned & shifted[15]}}, shifted[15:0]};
			default:            loadVal = readWord;
		endcase
	end

	always_comb begin
		case (wbSel)
			rvCtrlPkg::wbMem:     wbData = memLoad ? loadVal : '0;
			rvCtrlPkg::wbPcPlus4: wbData = pcPlus4;
			default:              wbData = aluResult;
		endcase
	end

endmodule

`default_nettype wire

//--- design/aluExecute.sv
`default_nettype none

module aluExecute (
	input  wire rvIsaPkg::word   pc,
	input  wire rvIsaPkg::word   rdata1,
	input  wire rvIsaPkg::word   rdata2,
	input  wire rvIsaPkg::word   imm,
	input  wire rvCtrlPkg::aluOp aluCtrl,
	input  wire                  aluSrcImm,
	input  wire                  aluSrcPc,
	input  wire                  isBranch,
	input  wire rvIsaPkg::funct3 branchFunct,
	input  wire                  isJal,
	input  wire                  isJalr,
	output rvIsaPkg::word        aluResult,
	output logic                 redirect,
	output rvIsaPkg::word        target
);

	rvIsaPkg::word opA;
	rvIsaPkg::word opB;
	logic [4:0]    shamt;
	logic          taken;

	assign opA = aluSrcPc ? pc : rdata1;
	assign opB = aluSrcImm ? imm : rdata2;
	assign shamt = opB[4:0];

	always_comb begin
		case (aluCtrl)
			rvCtrlPkg::aluAdd:   aluResult = opA + opB;
			rvCtrlPkg::aluSub:   aluResult = opA - opB;
			rvCtrlPkg::aluSll:   aluResult = opA << shamt;
			rvCtrlPkg::aluSlt:   aluResult = {31'b0, $signed(opA) < $signed(opB)};
			rvCtrlPkg::aluSltu:  aluResult = {31'b0, opA < opB};
			rvCtrlPkg::aluXor:   aluResult = opA ^ opB;
			rvCtrlPkg::aluSrl:   aluResult = opA >> shamt;
			rvCtrlPkg::aluSra:   aluResult = $signed(opA) >>> shamt;
			rvCtrlPkg::aluOr:    aluResult = opA | opB;
			rvCtrlPkg::aluAnd:   aluResult = opA & opB;
			rvCtrlPkg::aluPassB: aluResult = opB;
			default:             aluResult = '0;
		endcase
	end

	// compare always on the two register operands
	always_comb begin
		case (branchFunct)
			rvIsaPkg::f3Beq:  taken = (rdata1 == rdata2);
			rvIsaPkg::f3Bne:  taken = (rdata1 != rdata2);
			rvIsaPkg::f3Blt:  taken = ($signed(rdata1) < $signed(rdata2));
			rvIsaPkg::f3Bge:  taken = ($signed(rdata1) >= $signed(rdata2));
			rvIsaPkg::f3Bltu: taken = (rdata1 < rdata2);
			rvIsaPkg::f3Bgeu: taken = (rdata1 >= rdata2);
			default:          taken = 1'b0;
		endcase
	end

	assign redirect = (isBranch && taken) || isJal || isJalr;
	// jalr sum is the alu add of rs1 and imm with bit 0 dropped
	assign target = isJalr ? {aluResult[31:1], 1'b0} : pc + imm;

endmodule

`default_nettype wire

//--- design/regFile.sv
`default_nettype none

module regFile (
	input  wire                   clk,
	input  wire                   rstN,
	input  wire                   we,
	input  wire rvIsaPkg::regAddr waddr,
	input  wire rvIsaPkg::word    wdata,
	input  wire rvIsaPkg::regAddr raddr1,
	input  wire rvIsaPkg::regAddr raddr2,
	output rvIsaPkg::word         rdata1,
	output rvIsaPkg::word         rdata2
);

	rvIsaPkg::word regs [32];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// x0 is never written, so it reads zero
	assign rdata1 = regs[raddr1];
	assign rdata2 = regs[raddr2];

endmodule

`default_nettype wire

//--- design/instDecoder.sv
`default_nettype none

module instDecoder (
	input  wire rvIsaPkg::word    inst,
	output rvIsaPkg::regAddr      rs1,
	output rvIsaPkg::regAddr      rs2,
	output rvIsaPkg::regAddr      rd,
	output rvIsaPkg::word         imm,
	output rvCtrlPkg::aluOp       aluCtrl,
	output logic                  aluSrcImm,
	output logic                  aluSrcPc,
	output logic                  regWrite,
	output logic                  memWrite,
	output logic                  memLoad,
	output rvCtrlPkg::memSize     memSz,
	output logic                  memUnsigned,
	output logic                  isBranch,
	output rvIsaPkg::funct3       branchFunct,
	output logic                  isJal,
	output logic                  isJalr,
	output logic                  isEbreak,
	output rvCtrlPkg::wbSrc       wbSel
);

	rvIsaPkg::opcode opc;
	rvIsaPkg::funct3 f3;
	rvIsaPkg::funct7 f7;
	rvIsaPkg::word   iImm;
	rvIsaPkg::word   sImm;
	rvIsaPkg::word   bImm;
	rvIsaPkg::word   uImm;
	rvIsaPkg::word   jImm;

	function automatic rvCtrlPkg::aluOp aluFromFunct3(
		input rvIsaPkg::funct3 f,
		input logic alt
	);
		case (f)
			rvIsaPkg::f3Add:  return alt ? rvCtrlPkg::aluSub : rvCtrlPkg::aluAdd;
			rvIsaPkg::f3Sll:  return rvCtrlPkg::aluSll;
			rvIsaPkg::f3Slt:  return rvCtrlPkg::aluSlt;
			rvIsaPkg::f3Sltu: return rvCtrlPkg::aluSltu;
			rvIsaPkg::f3Xor:  return rvCtrlPkg::aluXor;
			rvIsaPkg::f3Sr:   return alt ? rvCtrlPkg::aluSra : rvCtrlPkg::aluSrl;
			rvIsaPkg::f3Or:   return rvCtrlPkg::aluOr;
			default:          return rvCtrlPkg::aluAnd;
		endcase
	endfunction

	assign opc = inst[6:0];
	assign f3  = inst[14:12];
	assign f7  = inst[31:25];

	assign iImm = {{20{inst[31]}}, inst[31:20]};
	assign sImm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign bImm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign uImm = {inst[31:12], 12'b0};
	assign jImm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	assign rs1 = inst[19:15];
	assign rs2 = inst[24:20];
	// no write means rd reads as x0
	assign rd = regWrite ? inst[11:7] : '0;
	assign branchFunct = f3;

	always_comb begin
		imm = '0;
		aluCtrl = rvCtrlPkg::aluAdd;
		aluSrcImm = 1'b0;
		aluSrcPc = 1'b0;
		regWrite = 1'b0;
		memWrite = 1'b0;
		memLoad = 1'b0;
		memSz = rvCtrlPkg::memWord;
		memUnsigned = 1'b0;
		isBranch = 1'b0;
		isJal = 1'b0;
		isJalr = 1'b0;
		isEbreak = 1'b0;
		wbSel = rvCtrlPkg::wbAlu;
		case (opc)
			rvIsaPkg::opLui: begin
				imm = uImm;
				aluCtrl = rvCtrlPkg::aluPassB;
				aluSrcImm = 1'b1;
				regWrite = 1'b1;
			end
			rvIsaPkg::opAuipc: begin
				imm = uImm;
				aluSrcImm = 1'b1;
				aluSrcPc = 1'b1;
				regWrite = 1'b1;
			end
			rvIsaPkg::opJal: begin
				imm = jImm;
				isJal = 1'b1;
				regWrite = 1'b1;
				wbSel = rvCtrlPkg::wbPcPlus4;
			end
			rvIsaPkg::opJalr: begin
				// target comes from the alu sum rs1 + imm
				imm = iImm;
				aluSrcImm = 1'b1;
				isJalr = 1'b1;
				regWrite = 1'b1;
				wbSel = rvCtrlPkg::wbPcPlus4;
			end
			rvIsaPkg::opBranch: begin
				imm = bImm;
				isBranch = 1'b1;
			end
			rvIsaPkg::opLoad: begin
				imm = iImm;
				aluSrcImm = 1'b1;
				memUnsigned = f3[2];
				wbSel = rvCtrlPkg::wbMem;
				case (f3)
					rvIsaPkg::f3Byte, rvIsaPkg::f3ByteU: begin
						memSz = rvCtrlPkg::memByte;
						memLoad = 1'b1;
						regWrite = 1'b1;
					end
					rvIsaPkg::f3Half, rvIsaPkg::f3HalfU: begin
						memSz = rvCtrlPkg::memHalf;
						memLoad = 1'b1;
						regWrite = 1'b1;
					end
					rvIsaPkg::f3Word: begin
						memLoad = 1'b1;
						regWrite = 1'b1;
					end
					default: ;
				endcase
			end
			rvIsaPkg::opStore: begin
				imm = sImm;
				aluSrcImm = 1'b1;
				case (f3)
					rvIsaPkg::f3Byte: begin
						memSz = rvCtrlPkg::memByte;
						memWrite = 1'b1;
					end
					rvIsaPkg::f3Half: begin
						memSz = rvCtrlPkg::memHalf;
						memWrite = 1'b1;
					end
					rvIsaPkg::f3Word: memWrite = 1'b1;
					default: ;
				endcase
			end
			rvIsaPkg::opImm: begin
				// shift immediates carry funct7 in the upper bits
				if (!(f3 == rvIsaPkg::f3Sll && f7 != rvIsaPkg::f7Base) &&
						!(f3 == rvIsaPkg::f3Sr && f7 != rvIsaPkg::f7Base &&
						f7 != rvIsaPkg::f7Alt)) begin
					imm = iImm;
					aluSrcImm = 1'b1;
					regWrite = 1'b1;
					aluCtrl = aluFromFunct3(f3, f3 == rvIsaPkg::f3Sr && f7 == rvIsaPkg::f7Alt);
				end
			end
			rvIsaPkg::opReg: begin
				if (f7 == rvIsaPkg::f7Base || (f7 == rvIsaPkg::f7Alt &&
						(f3 == rvIsaPkg::f3Add || f3 == rvIsaPkg::f3Sr))) begin
					regWrite = 1'b1;
					aluCtrl = aluFromFunct3(f3, f7 == rvIsaPkg::f7Alt);
				end
			end
			rvIsaPkg::opSystem: isEbreak = (inst == rvIsaPkg::ebreakInst);
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- design/rvCtrlPkg.sv
`default_nettype none

package rvCtrlPkg;

	// passB feeds the immediate straight through for LUI
	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluSll,
		aluSlt,
		aluSltu,
		aluXor,
		aluSrl,
		aluSra,
		aluOr,
		aluAnd,
		aluPassB
	} aluOp;

	// write-back source
	typedef enum logic [1:0] {
		wbAlu,
		wbMem,
		wbPcPlus4
	} wbSrc;

	// data memory access size
	typedef enum logic [1:0] {
		memByte,
		memHalf,
		memWord
	} memSize;

endpackage

`default_nettype wire

//--- design/rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

	typedef logic [31:0] word;
	typedef logic [4:0] regAddr;
	typedef logic [6:0] opcode;
	typedef logic [2:0] funct3;
	typedef logic [6:0] funct7;

	// major opcodes in inst[6:0]
	localparam opcode opLui    = 7'b0110111;
	localparam opcode opAuipc  = 7'b0010111;
	localparam opcode opJal    = 7'b1101111;
	localparam opcode opJalr   = 7'b1100111;
	localparam opcode opBranch = 7'b1100011;
	localparam opcode opLoad   = 7'b0000011;
	localparam opcode opStore  = 7'b0100011;
	localparam opcode opImm    = 7'b0010011;
	localparam opcode opReg    = 7'b0110011;
	localparam opcode opSystem = 7'b1110011;

	// alu funct3
	localparam funct3 f3Add  = 3'b000;
	localparam funct3 f3Sll  = 3'b001;
	localparam funct3 f3Slt  = 3'b010;
	localparam funct3 f3Sltu = 3'b011;
	localparam funct3 f3Xor  = 3'b100;
	localparam funct3 f3Sr   = 3'b101;
	localparam funct3 f3Or   = 3'b110;
	localparam funct3 f3And  = 3'b111;

	// branch funct3
	localparam funct3 f3Beq  = 3'b000;
	localparam funct3 f3Bne  = 3'b001;
	localparam funct3 f3Blt  = 3'b100;
	localparam funct3 f3Bge  = 3'b101;
	localparam funct3 f3Bltu = 3'b110;
	localparam funct3 f3Bgeu = 3'b111;

	// load and store widths
	localparam funct3 f3Byte  = 3'b000;
	localparam funct3 f3Half  = 3'b001;
	localparam funct3 f3Word  = 3'b010;
	localparam funct3 f3ByteU = 3'b100;
	localparam funct3 f3HalfU = 3'b101;

	localparam funct7 f7Base = 7'b0000000;
	localparam funct7 f7Alt  = 7'b0100000;

	localparam word ebreakInst = 32'h0010_0073;

endpackage

`default_nettype wire
